// ==== Makefile ====
TOP = parking_lot_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f all.f -o sim

run: compile
	./obj_dir/sim | tee sim.log
	@if grep -q "Verification failed" sim.log; then exit 1; fi
	@grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== all.f ====
hw/parking_pkg.sv
hw/order_queue.sv
hw/slot_table.sv
hw/spot_finder.sv
hw/elevator_controller.sv
hw/parking_lot_top.sv
dv/parking_lot_tb.sv

// ==== dv/order_input.txt ====
// op plate slot status: op bit 0 is retrieve, bit 1 submits with no idle gap, f ends
// slot and status are the expected result; status 0 ok, 1 lot full, 2 not found
0 1002 4 0
0 8004 5 0
0 9006 8 0
0 1235 2 0
0 8237 3 0
0 9239 6 0
1 8004 5 0
0 200a 5 0
1 1235 2 0
0 3451 2 0
1 9006 8 0
1 5555 0 2
0 400c 8 0
0 500e 9 0
0 6010 c 0
0 7012 d 0
0 a014 0 1
1 7777 0 2
1 6010 c 0
0 c018 c 0
2 1101 7 0
2 1103 a 0
2 1105 b 0
2 1107 e 0
2 1109 f 0
2 110b 0 1
3 1109 f 0
3 1107 e 0
3 c018 c 0
3 500e 9 0
2 110d e 0
3 1105 b 0
3 1103 a 0
1 9239 6 0
1 1002 4 0
1 8237 3 0
f 0 0 0

// ==== dv/parking_lot_tb.sv ====
// Parking tower testbench
// Replays the orders of dv/order_input.txt and checks each result in submission order
`timescale 1ns/1ps
`default_nettype none

module parking_lot_tb import parking_pkg::*; ();

	localparam int max_orders = 64;
	localparam int ack_limit  = 100;  // Cycles allowed per handshake phase
	localparam int done_limit = 500;  // Cycles allowed per result

	logic    clock;
	logic    reset;
	logic    order_req;
	logic    order_retrieve;
	plate_t  order_plate;
	logic    order_ack;
	logic    done_valid;
	plate_t  done_plate;
	slot_t   done_slot;
	status_t done_status;
	fee_t    done_fee;

	logic [15:0] stim [4*max_orders];  // Op, plate, slot and status words for each order
	logic [31:0] lfsr;
	logic        timed_out;  // Set once any wait loop runs out of cycles
	int num_orders;
	int acked;
	int done_count;
	int checks;
	int errors;
	int stalls;  // Handshakes that waited on a full queue

	parking_lot_top u_dut (
		.clock          (clock),
		.reset          (reset),
		.order_req      (order_req),
		.order_retrieve (order_retrieve),
		.order_plate    (order_plate),
		.order_ack      (order_ack),
		.done_valid     (done_valid),
		.done_plate     (done_plate),
		.done_slot      (done_slot),
		.done_status    (done_status),
		.done_fee       (done_fee)
	);

	always #10 clock = ~clock;

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// Three LFSR bits give the idle cycles before a submission
	task automatic draw_gap(output int gap);
		gap = 0;
		for (int b = 0; b < 3; b++) begin
			lfsr = lfsr_next(lfsr);
			gap = gap * 2 + int'(lfsr[0]);
		end
	endtask

	// Fee per clock by plate class
	function automatic int fee_rate(input plate_t plate);
		case (plate[15:12])
			4'h9:    return 0;
			4'h8:    return 1;
			default: return 2;
		endcase
	endfunction

	task automatic report_timeout(input string what);
		$display("%s", what);
		errors++;
		timed_out = 1'b1;
	endtask

	task automatic check_plate(input string name, input plate_t got, input plate_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_slot(input string name, input slot_t got, input slot_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_status(input string name, input status_t got, input status_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_fee(input string name, input fee_t got, input fee_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	// Retrieve fee depends on the parking time and follows its class rule
	task automatic check_fee_rule(input string name, input fee_t got, input plate_t plate);
		int rate;
		int limit;
		logic bad;
		rate  = fee_rate(plate);
		limit = (rate == 0) ? 0 : (255 / rate) * rate;  // Top multiple of the rate
		if (rate == 0)
			bad = (got != 0);
		else
			bad = (got == 0) || (int'(got) % rate != 0) || (int'(got) > limit);
		checks++;
		if (bad) begin
			errors++;
			$display("ERR %s got %h for rate %0d limit %h", name, got, rate, limit[7:0]);
		end
	endtask

	// Four-phase handshake started just after a rising edge
	task automatic submit_order(input int idx);
		int waited;
		order_req      = 1'b1;
		order_retrieve = stim[4*idx][0];
		order_plate    = stim[4*idx+1];
		waited = 0;
		while (!order_ack && !timed_out && waited < ack_limit) begin
			@(posedge clock);
			#1;
			waited++;
		end
		if (!order_ack) begin
			order_req = 1'b0;
			if (!timed_out)
				report_timeout($sformatf("order %0d never received order_ack", idx));
		end else begin
			if (waited > 2)
				stalls++;  // Full queue held the ack back
			acked++;
			checks++;
			if (acked - done_count > 9) begin
				errors++;
				$display("more than nine orders in flight after order %0d was accepted", idx);
			end
			order_req = 1'b0;
			waited = 0;
			while (order_ack && !timed_out && waited < ack_limit) begin
				@(posedge clock);
				#1;
				waited++;
			end
			if (order_ack && !timed_out)
				report_timeout($sformatf("order_ack stayed high after order %0d", idx));
		end
	endtask

	task automatic run_orders();
		int gap;
		for (int i = 0; i < num_orders && !timed_out; i++) begin
			if (!stim[4*i][1]) begin  // Back to back rows skip the gap
				draw_gap(gap);
				repeat (gap) begin
					@(posedge clock);
					#1;
				end
			end
			submit_order(i);
		end
	endtask

	task automatic collect_results();
		int waited;
		int err_before;
		logic retrieve;
		plate_t plate;
		status_t exp_status;
		for (int i = 0; i < num_orders && !timed_out; i++) begin
			waited = 1;
			@(posedge clock);
			#1;
			while (!done_valid && !timed_out && waited < done_limit) begin
				@(posedge clock);
				#1;
				waited++;
			end
			if (!done_valid) begin
				if (!timed_out)
					report_timeout($sformatf("no result for order %0d", i));
			end else begin
				retrieve   = stim[4*i][0];
				plate      = stim[4*i+1];
				exp_status = status_t'(stim[4*i+3]);
				err_before = errors;
				check_plate("done_plate", done_plate, plate);
				check_slot("done_slot", done_slot, slot_t'(stim[4*i+2]));
				check_status("done_status", done_status, exp_status);
				if (retrieve && exp_status == status_ok)
					check_fee_rule("done_fee", done_fee, plate);
				else
					check_fee("done_fee", done_fee, fee_t'(0));
				done_count++;
				$display("order %0d %s %h slot %h status %0d fee %h %s", i,
					retrieve ? "retrieve" : "park", plate, done_slot, done_status, done_fee,
					(errors == err_before) ? "ok" : "mismatch");
			end
		end
	endtask

	initial begin
		clock          = 1'b0;
		reset          = 1'b1;
		order_req      = 1'b0;
		order_retrieve = 1'b0;
		order_plate    = '0;
		lfsr           = 32'h6fb6;
		timed_out      = 1'b0;
		acked          = 0;
		done_count     = 0;
		checks         = 0;
		errors         = 0;
		stalls         = 0;
		for (int i = 0; i < 4*max_orders; i++)
			stim[i] = 16'h000f;  // End marker where the file stops
		$readmemh("dv/order_input.txt", stim);
		num_orders = 0;
		while (num_orders < max_orders && stim[4*num_orders] != 16'h000f)
			num_orders++;
		if (num_orders == 0) begin
			errors++;
			$display("no orders read from dv/order_input.txt");
		end

		repeat (8) @(posedge clock);
		#1;
		reset = 1'b0;

		fork
			run_orders();
			collect_results();
		join

		checks++;
		if (stalls == 0) begin
			errors++;
			$display("order queue never held back order_ack while full");
		end
		$display("orders %0d checks %0d errors %0d", num_orders, checks, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hw/elevator_controller.sv ====
// Elevator controller
// Takes one order at a time, travels to its spot and back, and reports the result
`timescale 1ns/1ps
`default_nettype none

module elevator_controller import parking_pkg::*; (
	input  wire     clock,
	input  wire     reset,
	input  wire     head_valid,
	input  wire     head_retrieve,
	input  plate_t  head_plate,
	input  slot_t   find_slot,
	input  wire     find_hit,
	input  fee_t    slot_fee,
	output logic    head_pop,
	output logic    park_en,
	output logic    clear_en,
	output slot_t   wr_slot,
	output plate_t  park_plate,
	output logic    done_valid,
	output plate_t  done_plate,
	output slot_t   done_slot,
	output status_t done_status,
	output fee_t    done_fee
);

	elev_state_t state;
	floor_t      floor;

	// Order held for the trip
	plate_t  plate_q;
	logic    retrieve_q;
	slot_t   slot_q;
	status_t status_q;
	fee_t    fee_q;
	floor_t  target;

	assign target = slot_q[3:1];

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= st_idle;
			floor <= '0;
		end else begin
			case (state)
				st_idle:
					if (head_valid)
						state <= find_hit ? st_up : st_report; // Misses skip the trip
				st_up: begin
					floor <= floor + 1'b1;
					if (floor + 1'b1 == target)
						state <= st_dock;
				end
				st_dock:
					state <= st_down;
				st_down: begin
					floor <= floor - 1'b1;
					if (floor == floor_t'(1))
						state <= st_report;
				end
				st_report:
					state <= st_idle;
				default:
					state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (head_pop) begin
			plate_q    <= head_plate;
			retrieve_q <= head_retrieve;
			slot_q     <= find_slot;
			fee_q      <= '0;
			if (find_hit)
				status_q <= status_ok;
			else
				status_q <= head_retrieve ? status_not_found : status_full;
		end
		if (clear_en)
			fee_q <= slot_fee; // Fee of the car leaving its spot
	end

	assign head_pop   = (state == st_idle) && head_valid;
	assign park_en    = (state == st_dock) && !retrieve_q;
	assign clear_en   = (state == st_dock) && retrieve_q;
	assign wr_slot    = slot_q;
	assign park_plate = plate_q;

	assign done_valid  = (state == st_report);
	assign done_plate  = plate_q;
	assign done_slot   = slot_q;
	assign done_status = status_q;
	assign done_fee    = fee_q;

	// Climbing never starts from the top floor, and results go out from floor 0
	a_floor_limit: assert property (@(posedge clock) disable iff (reset)
		state == st_up |-> floor < num_floors);
	a_home_floor: assert property (@(posedge clock) disable iff (reset)
		state inside {st_idle, st_report} |-> floor == '0);

endmodule

`default_nettype wire

// ==== hw/order_queue.sv ====
// Order queue
// Four-phase order intake into an eight-entry FIFO for the elevator
`timescale 1ns/1ps
`default_nettype none

module order_queue import parking_pkg::*; (
	input  wire    clock,
	input  wire    reset,
	input  wire    order_req,
	input  wire    order_retrieve,
	input  plate_t order_plate,
	input  wire    head_pop,
	output logic   order_ack,
	output logic   head_valid,
	output logic   head_retrieve,
	output plate_t head_plate
);

	plate_t plate_mem [queue_depth];
	logic   retrieve_mem [queue_depth];

	logic [$clog2(queue_depth)-1:0] wr_ptr, rd_ptr;
	logic [$clog2(queue_depth+1)-1:0] count;
	logic taken;  // Current request already stored, waiting for handshake to close
	logic full;
	logic push;

	assign full = (count == queue_depth);
	assign push = order_req && !taken && !full; // Full queue holds off the ack

	// Handshake and pointers
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			taken     <= 1'b0;
			order_ack <= 1'b0;
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
		end else begin
			if (push)
				taken <= 1'b1;
			else if (!order_req)
				taken <= 1'b0;
			order_ack <= order_req && taken; // Drops once the requester drops req

			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (head_pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (push && !head_pop)
				count <= count + 1'b1;
			else if (head_pop && !push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (push) begin
			plate_mem[wr_ptr]    <= order_plate;
			retrieve_mem[wr_ptr] <= order_retrieve;
		end
	end

	assign head_valid    = (count != 0);
	assign head_retrieve = retrieve_mem[rd_ptr];
	assign head_plate    = plate_mem[rd_ptr];

	// Elevator only pops a present entry, and the count stays in range
	a_pop_valid: assert property (@(posedge clock) disable iff (reset) head_pop |-> head_valid);
	a_count_range: assert property (@(posedge clock) disable iff (reset) count <= queue_depth);

endmodule

`default_nettype wire

// ==== hw/parking_lot_top.sv ====
// Parking tower top
// Order queue, spot finder, slot table and elevator controller
`timescale 1ns/1ps
`default_nettype none

module parking_lot_top import parking_pkg::*; (
	input  wire     clock,
	input  wire     reset,
	input  wire     order_req,
	input  wire     order_retrieve,
	input  plate_t  order_plate,
	output logic    order_ack,
	output logic    done_valid,
	output plate_t  done_plate,
	output slot_t   done_slot,
	output status_t done_status,
	output fee_t    done_fee
);

	logic   head_valid;
	logic   head_retrieve;
	plate_t head_plate;
	logic   head_pop;
	slot_t  find_slot;
	logic   find_hit;
	logic   park_en;
	logic   clear_en;
	slot_t  wr_slot;
	plate_t park_plate;
	fee_t   slot_fee;
	plate_t slot_plates [num_slots];

	order_queue u_queue (
		.clock          (clock),
		.reset          (reset),
		.order_req      (order_req),
		.order_retrieve (order_retrieve),
		.order_plate    (order_plate),
		.head_pop       (head_pop),
		.order_ack      (order_ack),
		.head_valid     (head_valid),
		.head_retrieve  (head_retrieve),
		.head_plate     (head_plate)
	);

	spot_finder u_finder (
		.head_retrieve (head_retrieve),
		.head_plate    (head_plate),
		.slot_plates   (slot_plates),
		.find_slot     (find_slot),
		.find_hit      (find_hit)
	);

	slot_table u_table (
		.clock       (clock),
		.reset       (reset),
		.park_en     (park_en),
		.clear_en    (clear_en),
		.wr_slot     (wr_slot),
		.park_plate  (park_plate),
		.slot_plates (slot_plates),
		.slot_fee    (slot_fee)
	);

	elevator_controller u_elevator (
		.clock         (clock),
		.reset         (reset),
		.head_valid    (head_valid),
		.head_retrieve (head_retrieve),
		.head_plate    (head_plate),
		.find_slot     (find_slot),
		.find_hit      (find_hit),
		.slot_fee      (slot_fee),
		.head_pop      (head_pop),
		.park_en       (park_en),
		.clear_en      (clear_en),
		.wr_slot       (wr_slot),
		.park_plate    (park_plate),
		.done_valid    (done_valid),
		.done_plate    (done_plate),
		.done_slot     (done_slot),
		.done_status   (done_status),
		.done_fee      (done_fee)
	);

endmodule

`default_nettype wire

// ==== hw/parking_pkg.sv ====
// Parking tower package
// Tower geometry, plate and fee types, result codes and elevator states
`default_nettype none

package parking_pkg;

	// Tower geometry
	localparam int num_floors  = 7;  // Storage floors above the entrance
	localparam int num_slots   = 14; // Two spots per storage floor
	localparam int queue_depth = 8;

	// Plate top nibble codes for the fee classes
	localparam logic [3:0] handicap_code = 4'd9;
	localparam logic [3:0] hybrid_code   = 4'd8;

	typedef logic [15:0] plate_t; // Zero marks an empty spot
	typedef logic [2:0]  floor_t;
	typedef logic [3:0]  slot_t;  // Floor times two plus place, right is 1
	typedef logic [7:0]  fee_t;
	typedef logic [1:0]  status_t;

	// Result codes
	localparam status_t status_ok        = 2'd0;
	localparam status_t status_full      = 2'd1;
	localparam status_t status_not_found = 2'd2;

	typedef enum logic [2:0] {
		st_idle,   // Waiting at floor 0 for an order
		st_up,
		st_dock,   // Loading or unloading at the target spot
		st_down,
		st_report
	} elev_state_t;

endpackage

`default_nettype wire

// ==== hw/slot_table.sv ====
// Slot table
// Plate storage for every spot and a saturating fee counter per spot
`timescale 1ns/1ps
`default_nettype none

module slot_table import parking_pkg::*; (
	input  wire    clock,
	input  wire    reset,
	input  wire    park_en,
	input  wire    clear_en,
	input  slot_t  wr_slot,
	input  plate_t park_plate,
	output plate_t slot_plates [num_slots],
	output fee_t   slot_fee
);

	fee_t  fees [num_slots];
	fee_t  rates [num_slots];
	slot_t wr_idx;

	// Fee per clock from the plate's top nibble
	function automatic fee_t rate_of(input plate_t plate);
		if (plate[15:12] == handicap_code)
			return fee_t'(0);
		else if (plate[15:12] == hybrid_code)
			return fee_t'(1);
		return fee_t'(2);
	endfunction

	assign wr_idx = wr_slot - slot_t'(2); // Floor 0 holds no spots

	always_comb begin
		for (int i = 0; i < num_slots; i++)
			rates[i] = rate_of(slot_plates[i]);
	end

	// Occupancy
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < num_slots; i++)
				slot_plates[i] <= '0;
		end else begin
			for (int i = 0; i < num_slots; i++) begin
				if (park_en && wr_idx == slot_t'(i))
					slot_plates[i] <= park_plate;
				else if (clear_en && wr_idx == slot_t'(i))
					slot_plates[i] <= '0;
			end
		end
	end

	// Counters stop one step below overflow, at the top multiple of the rate
	always_ff @(posedge clock) begin
		for (int i = 0; i < num_slots; i++) begin
			if (park_en && wr_idx == slot_t'(i))
				fees[i] <= '0;
			else if (slot_plates[i] != '0 && fees[i] <= fee_t'(8'hff) - rates[i])
				fees[i] <= fees[i] + rates[i];
		end
	end

	assign slot_fee = (wr_idx < num_slots) ? fees[wr_idx] : '0;

	a_one_write: assert property (@(posedge clock) disable iff (reset) !(park_en && clear_en));

endmodule

`default_nettype wire

// ==== hw/spot_finder.sv ====
// Spot finder
// Picks the park spot for the head order, or finds the spot holding its plate
`timescale 1ns/1ps
`default_nettype none

module spot_finder import parking_pkg::*; (
	input  wire    head_retrieve,
	input  plate_t head_plate,
	input  plate_t slot_plates [num_slots],
	output slot_t  find_slot,
	output logic   find_hit
);

	always_comb begin
		find_slot = '0;
		find_hit  = 1'b0;
		if (head_retrieve) begin
			// Plate match over the whole tower
			for (int i = 0; i < num_slots; i++) begin
				if (!find_hit && head_plate != '0 && slot_plates[i] == head_plate) begin
					find_hit  = 1'b1;
					find_slot = slot_t'(i + 2);
				end
			end
		end else begin
			// Odd plates on odd floors, even plates on even floors, lowest first
			for (int f = 1; f <= num_floors; f++) begin
				if (!find_hit && f[0] == head_plate[0]) begin
					if (slot_plates[2*f-2] == '0) begin // Left spot
						find_hit  = 1'b1;
						find_slot = slot_t'(2*f);
					end else if (slot_plates[2*f-1] == '0) begin
						find_hit  = 1'b1;
						find_slot = slot_t'(2*f + 1);
					end
				end
			end
		end
	end

endmodule

`default_nettype wire
